/* Makefile */
# Verilator build and run of the SoC bus testbench

TOP       ?= tb_soc_top
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
FILELIST  ?= soc_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP VERILATOR FLAGS FILELIST OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* bench/soc_testdata.txt */
# op addr wdata mask expect; W write, R read, P poll, G drive gpio_i, Q random RAM run
# R/P: mask column is the expected timer_irq_o; G: expect is {oe, out}; Q: wdata is run length
W 00000000 11223344 f 00000000
W 00000004 aabbccdd f 00000000
W 00000008 deadbeef f 00000000
W 00000000 55667788 5 00000000
W 00000004 01020304 a 00000000
W 00000008 00000000 c 00000000
R 00000000 00000000 0 11663388
R 00000004 00000000 0 01bb03dd
R 00000008 00000000 0 0000beef
# unmapped region 7
R 70000010 00000000 0 00000000
W 70000004 ffffffff f 00000000
R 00000004 00000000 0 01bb03dd
# timer, compare 20 with irq on
W 10000008 00000014 f 00000000
R 10000008 00000000 0 00000014
W 10000000 00000003 f 00000000
P 10000000 00000000 1 00000007
W 10000000 00000000 f 00000000
R 10000000 00000000 0 00000000
# gpio, pin 0 out and pin 1 in
W 20000000 00000009 f 00000000
W 20000004 00000001 f 00000000
G 00000000 00000002 0 00000005
R 20000004 00000000 0 00000003
R 20000000 00000000 0 00000009
# random back-to-back RAM traffic
Q 00000000 00000020 f 00000000

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // free running, first rising edge at half a period
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* bench/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top import soc_pkg::*; ();

    localparam int RAM_WORDS       = 256;
    localparam int DRIVE_DLY       = 2;
    localparam int CYCLES_PER_LINE = 64;
    localparam int TIMEOUT_BASE    = 2000;
    localparam int POLL_MAX        = 100;

    logic              clk;
    logic              rst_ext;
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wmask;
    logic              addr_ok;
    logic [DATA_W-1:0] rdata;
    logic              data_ok;
    logic              err;
    logic              timer_irq;
    logic [1:0]        gpio_in;
    logic [1:0]        gpio_out;
    logic [1:0]        gpio_oe;

    // one entry per test data line
    logic [7:0]        op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic [DATA_W-1:0] aux_q[$];
    logic [DATA_W-1:0] exp_q[$];
    int                line_q[$];

    logic [DATA_W-1:0] ram_model [RAM_WORDS];
    logic [31:0]       lcg_state;
    int                cycles      = 0;
    int                cycle_limit = TIMEOUT_BASE;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk_o(clk));

    soc_top #(
        .RAM_WORDS (RAM_WORDS)
    ) DUT (
        .clk         (clk),
        .rst_ext_i   (rst_ext),
        .req_i       (req),
        .we_i        (we),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .wmask_i     (wmask),
        .addr_ok_o   (addr_ok),
        .rdata_o     (rdata),
        .data_ok_o   (data_ok),
        .err_o       (err),
        .timer_irq_o (timer_irq),
        .gpio_i      (gpio_in),
        .gpio_o      (gpio_out),
        .gpio_oe_o   (gpio_oe)
    );

    ////////////////////////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_pins(input string name, input logic [1:0] exp_out,
                              input logic [1:0] exp_oe);
        if (gpio_out !== exp_out || gpio_oe !== exp_oe) begin
            $display("mismatch %s: expected out=%b oe=%b, actual out=%b oe=%b",
                     name, exp_out, exp_oe, gpio_out, gpio_oe);
            stop_failed();
        end
    endtask

    // hang guard with a limit from the number of test lines
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            stop_failed();
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic region_unmapped(input logic [ADDR_W-1:0] a);
        bus_addr_u ba;
        ba.raw = a;
        return !(ba.f.region == REGION_RAM || ba.f.region == REGION_TIMER ||
                 ba.f.region == REGION_GPIO);
    endfunction

    function automatic logic region_is_ram(input logic [ADDR_W-1:0] a);
        bus_addr_u ba;
        ba.raw = a;
        return ba.f.region == REGION_RAM;
    endfunction

    // word index above the byte lanes wraps at the RAM size
    function automatic int ram_index(input logic [ADDR_W-1:0] a);
        return int'((a / STRB_W) % RAM_WORDS);
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [STRB_W-1:0] m);
        int idx;
        idx = ram_index(a);
        for (int b = 0; b < STRB_W; b++) begin
            if (m[b]) begin
                ram_model[idx][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic read_testdata();
        int          fd;
        int          cnt;
        int          lineno;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] e;
        lineno = 0;
        fd = $fopen("bench/soc_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/soc_testdata.txt");
            stop_failed();
        end
        while ($fgets(line, fd) != 0) begin
            lineno++;
            if (line.len() > 0 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%c %h %h %h %h", op, a, d, m, e);
                if (cnt == 5) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    aux_q.push_back(m);
                    exp_q.push_back(e);
                    line_q.push_back(lineno);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // bus master
    ////////////////////////////////////////////////////////////

    task automatic drive_req(input logic w, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] m);
        req   = 1'b1;
        we    = w;
        addr  = a;
        wdata = d;
        wmask = m;
    endtask

    task automatic drive_idle();
        req   = 1'b0;
        we    = 1'b0;
        wmask = '0;
    endtask

    // entered and left just after a rising edge
    task automatic bus_access(input logic w, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] m,
                              output logic [DATA_W-1:0] rd, output logic er);
        drive_req(w, a, d, m);
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        while (!data_ok) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        rd = rdata;
        er = err;
    endtask

    task automatic run_write(input string name, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] m);
        logic [DATA_W-1:0] rd;
        logic              er;
        bus_access(1'b1, a, d, m, rd, er);
        check_flag({name, " err"}, region_unmapped(a), er);
        if (region_is_ram(a)) begin
            model_write(a, d, m);
        end
    endtask

    task automatic run_read(input string name, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] exp, input logic irq_exp);
        logic [DATA_W-1:0] rd;
        logic              er;
        bus_access(1'b0, a, '0, '0, rd, er);
        check_word({name, " rdata"}, exp, rd);
        check_flag({name, " err"}, region_unmapped(a), er);
        check_flag({name, " irq"}, irq_exp, timer_irq);
    endtask

    task automatic run_poll(input string name, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] exp, input logic irq_exp);
        logic [DATA_W-1:0] rd;
        logic              er;
        logic              matched;
        int                tries;
        matched = 1'b0;
        tries   = 0;
        while (!matched) begin
            bus_access(1'b0, a, '0, '0, rd, er);
            tries++;
            matched = (rd === exp);
            if (!matched && tries >= POLL_MAX) begin
                $display("%s never read %h in %0d polls, last value %h",
                         name, exp, tries, rd);
                stop_failed();
            end
        end
        check_flag({name, " err"}, region_unmapped(a), er);
        check_flag({name, " irq"}, irq_exp, timer_irq);
    endtask

    // expect column holds {oe, out}
    task automatic run_gpio(input string name, input logic [DATA_W-1:0] pins,
                            input logic [DATA_W-1:0] exp);
        gpio_in = pins[1:0];
        @(posedge clk);
        #DRIVE_DLY;
        check_pins(name, exp[1:0], exp[3:2]);
    endtask

    // writes then reads of the same words at one request per cycle
    task automatic run_random(input string name, input logic [ADDR_W-1:0] base,
                              input int count, input logic [STRB_W-1:0] m);
        logic [ADDR_W-1:0] run_addr[$];
        logic [DATA_W-1:0] run_data[$];
        logic              run_we[$];
        logic [DATA_W-1:0] prev_exp;
        logic              prev_we;
        int                total;
        prev_exp = '0;
        prev_we  = 1'b1;
        for (int i = 0; i < count; i++) begin
            lcg_state = lcg_next(lcg_state);
            run_addr.push_back(base + ((lcg_state >> 8) % RAM_WORDS) * STRB_W);
            lcg_state = lcg_next(lcg_state);
            run_data.push_back(lcg_state);
            run_we.push_back(1'b1);
        end
        for (int i = 0; i < count; i++) begin
            run_addr.push_back(run_addr[i]);
            run_data.push_back('0);
            run_we.push_back(1'b0);
        end
        total = run_we.size();
        for (int i = 0; i <= total; i++) begin
            if (i > 0) begin
                check_flag($sformatf("%s op %0d data_ok", name, i - 1), 1'b1, data_ok);
                check_flag($sformatf("%s op %0d err", name, i - 1), 1'b0, err);
                if (!prev_we) begin
                    check_word($sformatf("%s op %0d rdata", name, i - 1), prev_exp, rdata);
                end
            end
            if (i < total) begin
                drive_req(run_we[i], run_addr[i], run_data[i], m);
                prev_we = run_we[i];
                if (run_we[i]) begin
                    model_write(run_addr[i], run_data[i], m);
                end else begin
                    prev_exp = ram_model[ram_index(run_addr[i])];
                end
                @(posedge clk);
                check_flag($sformatf("%s op %0d addr_ok", name, i), 1'b1, addr_ok);
                #DRIVE_DLY;
            end else begin
                drive_idle();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        string name;
        rst_ext   = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        wmask     = '0;
        gpio_in   = 2'b00;
        lcg_state = 32'hdf32;

        read_testdata();
        cycle_limit = op_q.size() * CYCLES_PER_LINE + TIMEOUT_BASE;

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_ext = 1'b1;
        // two more edges through the synchronizer
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        check_flag("reset data_ok", 1'b0, data_ok);
        check_flag("reset err", 1'b0, err);
        check_flag("reset irq", 1'b0, timer_irq);
        check_pins("reset gpio", 2'b00, 2'b00);

        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("%c line %0d", op_q[i], line_q[i]);
            case (op_q[i])
                "W": run_write(name, addr_q[i], data_q[i], aux_q[i][STRB_W-1:0]);
                "R": run_read(name, addr_q[i], exp_q[i], aux_q[i][0]);
                "P": run_poll(name, addr_q[i], exp_q[i], aux_q[i][0]);
                "G": run_gpio(name, data_q[i], exp_q[i]);
                "Q": run_random(name, addr_q[i], int'(data_q[i]), aux_q[i][STRB_W-1:0]);
                default: begin
                    $display("unknown operation %c on line %0d", op_q[i], line_q[i]);
                    stop_failed();
                end
            endcase
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* soc_top.f */
source/soc_pkg.sv
source/bus_ctrl.sv
source/data_ram.sv
source/timer.sv
source/gpio.sv
source/soc_top.sv
bench/tb_clock.sv
bench/tb_soc_top.sv

/* source/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    // master side
    input  logic                req_i,
    input  logic                we_i,
    input  bus_addr_u           addr_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic [STRB_W-1:0]   wmask_i,
    output logic                addr_ok_o,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                data_ok_o,
    output logic                err_o,
    // target side
    output logic                ram_sel_o,
    output logic                tmr_sel_o,
    output logic                gpio_sel_o,
    output logic                we_o,
    output logic [OFS_W-1:0]    ofs_o,
    output logic [DATA_W-1:0]   wdata_o,
    output logic [STRB_W-1:0]   wmask_o,
    input  logic [DATA_W-1:0]   ram_rdata_i,
    input  logic [DATA_W-1:0]   tmr_rdata_i,
    input  logic [DATA_W-1:0]   gpio_rdata_i
);

    logic                req_mapped;
    logic                rsp_vld;
    logic                rsp_err;
    logic [REGION_W-1:0] rsp_region;

    ////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////

    // every request is taken in the cycle it shows up
    assign addr_ok_o = req_i;

    assign ram_sel_o  = req_i && (addr_i.f.region == REGION_RAM);
    assign tmr_sel_o  = req_i && (addr_i.f.region == REGION_TIMER);
    assign gpio_sel_o = req_i && (addr_i.f.region == REGION_GPIO);
    assign req_mapped = ram_sel_o || tmr_sel_o || gpio_sel_o;

    // shared fields fan out to all targets
    assign we_o    = we_i;
    assign ofs_o   = addr_i.f.ofs;
    assign wdata_o = wdata_i;
    assign wmask_o = wmask_i;

    ////////////////////////////////////////////////////////////
    // response stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_vld    <= 1'b0;
            rsp_err    <= 1'b0;
            rsp_region <= '0;
        end else begin
            rsp_vld <= req_i;
            rsp_err <= req_i && !req_mapped;
            if (req_i) begin
                rsp_region <= addr_i.f.region;
            end
        end
    end

    assign data_ok_o = rsp_vld;
    assign err_o     = rsp_err;

    // unmapped reads come back as zero
    always_comb begin
        case (rsp_region)
            REGION_RAM:   rdata_o = ram_rdata_i;
            REGION_TIMER: rdata_o = tmr_rdata_i;
            REGION_GPIO:  rdata_o = gpio_rdata_i;
            default:      rdata_o = '0;
        endcase
    end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram import soc_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk,
    input  logic                sel_i,
    input  logic                we_i,
    input  logic [OFS_W-1:0]    ofs_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic [STRB_W-1:0]   wmask_i,
    output logic [DATA_W-1:0]   rdata_o
);

    localparam int IDX_W  = $clog2(RAM_WORDS);
    localparam int LANE_W = $clog2(STRB_W);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;

    // word index sits above the byte lane bits, upper bits wrap
    assign idx = ofs_i[LANE_W +: IDX_W];

    // byte-masked write
    always_ff @(posedge clk) begin
        if (sel_i && we_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wmask_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a write
    always_ff @(posedge clk) begin
        if (sel_i) begin
            rdata_o <= mem[idx];
        end
    end

endmodule

/* source/gpio.sv */
`timescale 1ns/1ps

module gpio import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic                we_i,
    input  logic [OFS_W-1:0]    ofs_i,
    input  logic [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   rdata_o,
    input  logic [1:0]          gpio_i,
    output logic [1:0]          gpio_o,
    output logic [1:0]          gpio_oe_o
);

    logic [3:0] mode;
    logic [1:0] data;
    logic [1:0] pin_in;

    // two mode bits per pin
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pin_in[i]    = (mode[2*i +: 2] == GPIO_MODE_IN);
            gpio_oe_o[i] = (mode[2*i +: 2] == GPIO_MODE_OUT);
            gpio_o[i]    = gpio_oe_o[i] && data[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mode <= '0;
            data <= '0;
        end else begin
            if (sel_i && we_i && ofs_i == GPIO_CTRL_OFS) begin
                mode <= wdata_i[3:0];
            end
            // input pins track the pads, bus writes only reach the rest
            for (int i = 0; i < 2; i++) begin
                if (pin_in[i]) begin
                    data[i] <= gpio_i[i];
                end else if (sel_i && we_i && ofs_i == GPIO_DATA_OFS) begin
                    data[i] <= wdata_i[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (ofs_i)
                GPIO_CTRL_OFS: rdata_o <= {{(DATA_W-4){1'b0}}, mode};
                GPIO_DATA_OFS: rdata_o <= {{(DATA_W-2){1'b0}}, data};
                default:       rdata_o <= '0;
            endcase
        end
    end

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int REGION_W = 4;
    localparam int OFS_W    = ADDR_W - REGION_W;

    // address regions, top nibble of the address
    localparam logic [REGION_W-1:0] REGION_RAM   = 4'd0;
    localparam logic [REGION_W-1:0] REGION_TIMER = 4'd1;
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'd2;

    // timer register map
    localparam logic [OFS_W-1:0] TIMER_CTRL_OFS  = 28'h0;
    localparam logic [OFS_W-1:0] TIMER_COUNT_OFS = 28'h4;
    localparam logic [OFS_W-1:0] TIMER_VALUE_OFS = 28'h8;

    // gpio register map
    localparam logic [OFS_W-1:0] GPIO_CTRL_OFS = 28'h0;
    localparam logic [OFS_W-1:0] GPIO_DATA_OFS = 28'h4;

    // per-pin mode codes, anything else is off
    localparam logic [1:0] GPIO_MODE_OUT = 2'b01;
    localparam logic [1:0] GPIO_MODE_IN  = 2'b10;

    // timer control bits
    localparam int TIMER_EN_BIT     = 0;
    localparam int TIMER_IRQ_EN_BIT = 1;
    localparam int TIMER_PEND_BIT   = 2;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFS_W-1:0]    ofs;
        } f;
    } bus_addr_u;

endpackage

/* source/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_ext_i,
    // bus master port
    input  logic                req_i,
    input  logic                we_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic [STRB_W-1:0]   wmask_i,
    output logic                addr_ok_o,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                data_ok_o,
    output logic                err_o,
    // peripherals
    output logic                timer_irq_o,
    input  logic [1:0]          gpio_i,
    output logic [1:0]          gpio_o,
    output logic [1:0]          gpio_oe_o
);

    logic [1:0]        rst_sync;
    logic              rst_n;
    bus_addr_u         bus_addr;

    logic              ram_sel;
    logic              tmr_sel;
    logic              gpio_sel;
    logic              tgt_we;
    logic [OFS_W-1:0]  tgt_ofs;
    logic [DATA_W-1:0] tgt_wdata;
    logic [STRB_W-1:0] tgt_wmask;
    logic [DATA_W-1:0] ram_rdata;
    logic [DATA_W-1:0] tmr_rdata;
    logic [DATA_W-1:0] gpio_rdata;

    ////////////////////////////////////////////////////////////
    // reset release, async assert and synced deassert
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_ext_i) begin
        if (!rst_ext_i) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_n        = rst_sync[1];
    assign bus_addr.raw = addr_i;

    ////////////////////////////////////////////////////////////
    // bus controller and targets
    ////////////////////////////////////////////////////////////

    bus_ctrl u_bus_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (bus_addr),
        .wdata_i      (wdata_i),
        .wmask_i      (wmask_i),
        .addr_ok_o    (addr_ok_o),
        .rdata_o      (rdata_o),
        .data_ok_o    (data_ok_o),
        .err_o        (err_o),
        .ram_sel_o    (ram_sel),
        .tmr_sel_o    (tmr_sel),
        .gpio_sel_o   (gpio_sel),
        .we_o         (tgt_we),
        .ofs_o        (tgt_ofs),
        .wdata_o      (tgt_wdata),
        .wmask_o      (tgt_wmask),
        .ram_rdata_i  (ram_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .gpio_rdata_i (gpio_rdata)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .sel_i   (ram_sel),
        .we_i    (tgt_we),
        .ofs_i   (tgt_ofs),
        .wdata_i (tgt_wdata),
        .wmask_i (tgt_wmask),
        .rdata_o (ram_rdata)
    );

    timer u_timer (
        .clk     (clk),
        .rst_n_i (rst_n),
        .sel_i   (tmr_sel),
        .we_i    (tgt_we),
        .ofs_i   (tgt_ofs),
        .wdata_i (tgt_wdata),
        .rdata_o (tmr_rdata),
        .irq_o   (timer_irq_o)
    );

    gpio u_gpio (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .sel_i     (gpio_sel),
        .we_i      (tgt_we),
        .ofs_i     (tgt_ofs),
        .wdata_i   (tgt_wdata),
        .rdata_o   (gpio_rdata),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule

/* source/timer.sv */
`timescale 1ns/1ps

module timer import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic                we_i,
    input  logic [OFS_W-1:0]    ofs_i,
    input  logic [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                irq_o
);

    localparam int CTRL_W = TIMER_PEND_BIT + 1;

    logic [CTRL_W-1:0] ctrl;
    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] cmp;
    logic              wr_en;

    assign wr_en = sel_i && we_i;

    ////////////////////////////////////////////////////////////
    // counter and registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl  <= '0;
            count <= '0;
            cmp   <= '0;
        end else begin
            if (ctrl[TIMER_EN_BIT]) begin
                // match wraps the count and raises pending
                if (count == cmp) begin
                    count                <= '0;
                    ctrl[TIMER_PEND_BIT] <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
            // bus write wins over the count update
            if (wr_en) begin
                case (ofs_i)
                    TIMER_CTRL_OFS:  ctrl  <= wdata_i[CTRL_W-1:0];
                    TIMER_COUNT_OFS: count <= wdata_i;
                    TIMER_VALUE_OFS: cmp   <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // read port
    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (ofs_i)
                TIMER_CTRL_OFS:  rdata_o <= {{(DATA_W-CTRL_W){1'b0}}, ctrl};
                TIMER_COUNT_OFS: rdata_o <= count;
                TIMER_VALUE_OFS: rdata_o <= cmp;
                default:         rdata_o <= '0;
            endcase
        end
    end

    assign irq_o = ctrl[TIMER_PEND_BIT] && ctrl[TIMER_IRQ_EN_BIT];

endmodule
